// ==== src/router_defines.svh ====
/* Mesh router sizing macros for port count, input FIFO depth
   and mesh coordinate width */
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// North, south, west, east and local
`define ROUTER_NUM_PORTS 5

// Entries per input FIFO and initial credit per output
`define ROUTER_BUF_DEPTH 4

// Bits in one of the y or x coordinates
`define ROUTER_COORD_W 4

`endif

// ==== src/router_pkg.sv ====
/* Router types for mesh coordinates, flit layout, port encoding
   and the head record an input unit hands to the arbiter */
`include "router_defines.svh"

package router_pkg;

  typedef struct packed {
    logic [`ROUTER_COORD_W-1:0] y;
    logic [`ROUTER_COORD_W-1:0] x;
  } coord_t;

  // Destination in the upper byte
  typedef struct packed {
    coord_t     dest;
    logic [7:0] payload;
  } flit_t;

  typedef enum logic [2:0] {
    PORT_N = 3'd0,
    PORT_S = 3'd1,
    PORT_W = 3'd2,
    PORT_E = 3'd3,
    PORT_L = 3'd4
  } port_e;

  typedef struct packed {
    logic  valid;
    port_e out_port;
    flit_t flit;
  } head_t;

endpackage

// ==== src/input_unit.sv ====
/* Circular flit FIFO for one router port with
   YX route computation for the flit at its head */
`include "router_defines.svh"

module input_unit (
  input  logic               clk,
  input  logic               reset_i,
  input  router_pkg::coord_t router_yx_i,
  input  router_pkg::flit_t  flit_i,
  input  logic               valid_i,
  input  logic               pop_i,
  output router_pkg::head_t  head_o
);

  localparam int DEPTH = `ROUTER_BUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  router_pkg::flit_t  mem [DEPTH];
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               push;
  logic               pop;
  router_pkg::flit_t  head_flit;
  router_pkg::port_e  route;

  // Upstream credits keep the FIFO from overflowing
  assign push = valid_i;
  assign pop  = pop_i && (count_q != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  assign head_flit = mem[rd_ptr_q];

  // Resolve y before x in YX order
  always_comb begin
    if (head_flit.dest.y > router_yx_i.y) begin
      route = router_pkg::PORT_S;
    end else if (head_flit.dest.y < router_yx_i.y) begin
      route = router_pkg::PORT_N;
    end else if (head_flit.dest.x > router_yx_i.x) begin
      route = router_pkg::PORT_E;
    end else if (head_flit.dest.x < router_yx_i.x) begin
      route = router_pkg::PORT_W;
    end else begin
      route = router_pkg::PORT_L;
    end
  end

  always_comb begin
    head_o.valid    = (count_q != '0);
    head_o.out_port = route;
    head_o.flit     = head_flit;
  end

endmodule

// ==== src/switch_arbiter.sv ====
/* Switch allocator with per-output round-robin arbiters and credit counters
   that produce input pops, upstream credits and crossbar selects */
`include "router_defines.svh"

module switch_arbiter (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  router_pkg::head_t [`ROUTER_NUM_PORTS-1:0]  heads_i,
  input  logic [`ROUTER_NUM_PORTS-1:0]               credit_i,
  output logic [`ROUTER_NUM_PORTS-1:0]               pop_o,
  output logic [`ROUTER_NUM_PORTS-1:0]               credit_o,
  output logic [`ROUTER_NUM_PORTS-1:0]               fire_o,
  output router_pkg::port_e [`ROUTER_NUM_PORTS-1:0]  sel_o
);

  localparam int NP    = `ROUTER_NUM_PORTS;
  localparam int PTR_W = $bits(router_pkg::port_e);
  localparam int CNT_W = $clog2(`ROUTER_BUF_DEPTH + 1);

  // req[out][in]
  logic [NP-1:0][NP-1:0]    req;
  logic [NP-1:0][PTR_W-1:0] rr_ptr_q;
  logic [NP-1:0][PTR_W-1:0] rr_ptr_d;
  logic [NP-1:0][CNT_W-1:0] credit_cnt_q;
  logic [NP-1:0][PTR_W-1:0] win_idx;
  logic [NP-1:0]            found;

  always_comb begin
    for (int o = 0; o < NP; o++) begin
      for (int i = 0; i < NP; i++) begin
        req[o][i] = heads_i[i].valid && (heads_i[i].out_port == router_pkg::port_e'(o));
      end
    end
  end

  always_comb begin : p_arb
    int j;
    j        = 0;
    pop_o    = '0;
    fire_o   = '0;
    found    = '0;
    win_idx  = '0;
    rr_ptr_d = rr_ptr_q;
    for (int o = 0; o < NP; o++) begin
      // First requester at or after the pointer with wraparound
      for (int k = 0; k < NP; k++) begin
        j = int'(rr_ptr_q[o]) + k;
        if (j >= NP) begin
          j = j - NP;
        end
        if (!found[o] && req[o][j]) begin
          found[o]   = 1'b1;
          win_idx[o] = PTR_W'(j);
        end
      end
      fire_o[o] = found[o] && (credit_cnt_q[o] != '0);
      if (fire_o[o]) begin
        pop_o[win_idx[o]] = 1'b1;
        rr_ptr_d[o] = (win_idx[o] == PTR_W'(NP - 1)) ? '0 : win_idx[o] + 1'b1;
      end
    end
  end

  always_comb begin
    for (int o = 0; o < NP; o++) begin
      sel_o[o] = router_pkg::port_e'(win_idx[o]);
    end
  end

  // Each freed input slot returns one credit upstream
  assign credit_o = pop_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rr_ptr_q <= '0;
      for (int o = 0; o < NP; o++) begin
        credit_cnt_q[o] <= CNT_W'(`ROUTER_BUF_DEPTH);
      end
    end else begin
      rr_ptr_q <= rr_ptr_d;
      for (int o = 0; o < NP; o++) begin
        // Send and return may coincide
        credit_cnt_q[o] <= credit_cnt_q[o] - CNT_W'(fire_o[o]) + CNT_W'(credit_i[o]);
      end
    end
  end

endmodule

// ==== src/crossbar_out.sv ====
/* Registered 5x5 crossbar that muxes the granted head flit onto
   each output and registers it with its valid strobe */
`include "router_defines.svh"

module crossbar_out (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  router_pkg::head_t [`ROUTER_NUM_PORTS-1:0]  heads_i,
  input  logic [`ROUTER_NUM_PORTS-1:0]               fire_i,
  input  router_pkg::port_e [`ROUTER_NUM_PORTS-1:0]  sel_i,
  output router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0]  out_flit_o,
  output logic [`ROUTER_NUM_PORTS-1:0]               out_valid_o
);

  localparam int NP = `ROUTER_NUM_PORTS;

  router_pkg::flit_t [NP-1:0] xbar_flit;

  // One input mux per output
  always_comb begin
    for (int o = 0; o < NP; o++) begin
      xbar_flit[o] = heads_i[sel_i[o]].flit;
    end
  end

  // Flit holds its last value between strobes
  always_ff @(posedge clk) begin
    for (int o = 0; o < NP; o++) begin
      if (fire_i[o]) begin
        out_flit_o[o] <= xbar_flit[o];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_valid_o <= '0;
    end else begin
      out_valid_o <= fire_i;
    end
  end

endmodule

// ==== src/mesh_router.sv ====
/* Five-port mesh router top with input units in a generate loop,
   switch arbiter and registered output crossbar */
`include "router_defines.svh"

module mesh_router (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  router_pkg::coord_t                         router_yx_i,
  input  router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0]  in_flit_i,
  input  logic [`ROUTER_NUM_PORTS-1:0]               in_valid_i,
  input  logic [`ROUTER_NUM_PORTS-1:0]               credit_i,
  output router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0]  out_flit_o,
  output logic [`ROUTER_NUM_PORTS-1:0]               out_valid_o,
  output logic [`ROUTER_NUM_PORTS-1:0]               credit_o
);

  localparam int NP = `ROUTER_NUM_PORTS;

  router_pkg::head_t [NP-1:0] heads;
  logic [NP-1:0]              pop;
  logic [NP-1:0]              fire;
  router_pkg::port_e [NP-1:0] sel;

  // Port index p follows the port_e order N, S, W, E, L
  for (genvar p = 0; p < NP; p++) begin : g_in
    input_unit i_input_unit (
      .clk         (clk),
      .reset_i     (reset_i),
      .router_yx_i (router_yx_i),
      .flit_i      (in_flit_i[p]),
      .valid_i     (in_valid_i[p]),
      .pop_i       (pop[p]),
      .head_o      (heads[p])
    );
  end

  switch_arbiter i_switch_arbiter (
    .clk      (clk),
    .reset_i  (reset_i),
    .heads_i  (heads),
    .credit_i (credit_i),
    .pop_o    (pop),
    .credit_o (credit_o),
    .fire_o   (fire),
    .sel_o    (sel)
  );

  // Output registers add the second cycle of latency
  crossbar_out i_crossbar_out (
    .clk         (clk),
    .reset_i     (reset_i),
    .heads_i     (heads),
    .fire_i      (fire),
    .sel_i       (sel),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
/* Testbench clock (period 20) and synchronous reset held for 16 cycles */

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release 2 units after the 16th edge
  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    #2;
    reset_o = 1'b0;
  end

endmodule

// ==== dv/router_tb.sv ====
/* Mesh router testbench with credit-based senders, downstream credit return,
   per (input, output) reference queues and six checks */
`include "router_defines.svh"

module router_tb;

  localparam int NP = `ROUTER_NUM_PORTS;
  localparam int DEPTH = `ROUTER_BUF_DEPTH;
  localparam int MY_Y = 2;
  localparam int MY_X = 2;
  localparam int ROUTE_FLITS = 40;
  localparam int RAND_FLITS = 40;
  localparam int BP_FLITS = 10;
  localparam int FAIR_FLITS = 40;
  localparam int FAIR_WARMUP = 20;
  localparam int FAIR_WINDOW = 80;
  localparam int ROUTE_WAIT = 20;
  localparam int RAND_WAIT = NP * RAND_FLITS * 4;
  localparam int BP_WAIT = BP_FLITS * 8;
  localparam int FAIR_WAIT = NP * DEPTH * 8;
  localparam int PE = int'(router_pkg::PORT_E);
  localparam int PL = int'(router_pkg::PORT_L);
  localparam int TIMEOUT_CYCLES = 20 + ROUTE_FLITS * (ROUTE_WAIT + 4) + RAND_WAIT
                                  + 40 + BP_WAIT + FAIR_WARMUP + FAIR_WINDOW
                                  + FAIR_WAIT + 500;

  logic                       clk;
  logic                       reset_i;
  router_pkg::coord_t         router_yx_i;
  router_pkg::flit_t [NP-1:0] in_flit_i;
  logic [NP-1:0]              in_valid_i;
  logic [NP-1:0]              credit_i;
  router_pkg::flit_t [NP-1:0] out_flit_o;
  logic [NP-1:0]              out_valid_o;
  logic [NP-1:0]              credit_o;

  router_pkg::flit_t tx_q [NP][$];
  router_pkg::flit_t exp_q [NP*NP][$];
  int                ret_q [NP][$];
  int                up_credit [NP];
  int                sent_cnt [NP];
  int                credit_seen [NP];
  int                got_cnt [NP][NP];
  logic [31:0]       rng_state;
  bit                dense;
  bit                hold_east;
  int                cycle;
  int                errors;
  int                tests_run;
  int                tests_failed;
  string             cur_test;

  tb_clock_gen i_tb_clock_gen (
    .clk_o   (clk),
    .reset_o (reset_i)
  );

  mesh_router i_mesh_router (
    .clk         (clk),
    .reset_i     (reset_i),
    .router_yx_i (router_yx_i),
    .in_flit_i   (in_flit_i),
    .in_valid_i  (in_valid_i),
    .credit_i    (credit_i),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o),
    .credit_o    (credit_o)
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Y first, then x
  function automatic int yx_route(router_pkg::flit_t f);
    if (f.dest.y > 4'(MY_Y)) return int'(router_pkg::PORT_S);
    if (f.dest.y < 4'(MY_Y)) return int'(router_pkg::PORT_N);
    if (f.dest.x > 4'(MY_X)) return int'(router_pkg::PORT_E);
    if (f.dest.x < 4'(MY_X)) return int'(router_pkg::PORT_W);
    return int'(router_pkg::PORT_L);
  endfunction

  // Random destination that lands on the given output
  function automatic router_pkg::coord_t dest_for(int out);
    router_pkg::coord_t d;
    logic [31:0]        r;
    r = next_random();
    d.y = 4'(MY_Y);
    d.x = 4'(MY_X);
    case (out)
      0: begin
        d.y = 4'(r % 2);
        d.x = r[11:8];
      end
      1: begin
        d.y = 4'(3 + r % 13);
        d.x = r[11:8];
      end
      2: d.x = 4'(r % 2);
      3: d.x = 4'(3 + r % 13);
      default: d.x = 4'(MY_X);
    endcase
    return d;
  endfunction

  function automatic router_pkg::coord_t random_dest();
    router_pkg::coord_t d;
    logic [31:0]        r;
    r = next_random();
    d.y = 4'(r % 5);
    d.x = 4'((r >> 8) % 5);
    return d;
  endfunction

  // Payload top bits carry the input index
  task automatic queue_flit(int in, router_pkg::coord_t dest);
    router_pkg::flit_t f;
    logic [31:0]       r;
    r = next_random();
    f.dest = dest;
    f.payload = {3'(in), r[4:0]};
    tx_q[in].push_back(f);
  endtask

  function automatic bit all_empty();
    for (int i = 0; i < NP; i++) begin
      if (tx_q[i].size() != 0 || ret_q[i].size() != 0) return 1'b0;
    end
    for (int n = 0; n < NP * NP; n++) begin
      if (exp_q[n].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic int out_total(int o);
    int sum;
    sum = 0;
    for (int i = 0; i < NP; i++) begin
      sum += got_cnt[i][o];
    end
    return sum;
  endfunction

  task automatic wait_drained(int limit);
    int n;
    n = 0;
    while (!all_empty() && n < limit) begin
      @(posedge clk);
      n++;
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic end_test(int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("PASS: %s", cur_test);
    end else begin
      tests_failed++;
      $display("FAIL: %s with %0d errors", cur_test, errors - err_before);
    end
  endtask

  always @(posedge clk) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles, stuck in %s",
               TIMEOUT_CYCLES, cur_test);
      $display("Some tests failed");
      $finish;
    end
  end

  // Upstream senders and downstream credit return
  initial begin : drive
    router_pkg::flit_t f;
    int                k;
    rng_state = 32'h86e7daa0;
    router_yx_i.y = 4'(MY_Y);
    router_yx_i.x = 4'(MY_X);
    in_flit_i = '0;
    in_valid_i = '0;
    credit_i = '0;
    dense = 1'b1;
    hold_east = 1'b0;
    for (int i = 0; i < NP; i++) begin
      up_credit[i] = DEPTH;
    end
    forever begin
      @(posedge clk);
      #2;
      in_valid_i = '0;
      credit_i = '0;
      for (int i = 0; i < NP; i++) begin
        if (tx_q[i].size() > 0 && up_credit[i] > 0 && (dense || next_random() % 2 == 0)) begin
          f = tx_q[i].pop_front();
          in_flit_i[i] = f;
          in_valid_i[i] = 1'b1;
          up_credit[i]--;
          sent_cnt[i]++;
          exp_q[i * NP + yx_route(f)].push_back(f);
        end
      end
      for (int o = 0; o < NP; o++) begin
        k = -1;
        if (!(hold_east && o == PE)) begin
          for (int n = 0; n < ret_q[o].size(); n++) begin
            if (k < 0 && ret_q[o][n] <= cycle) k = n;
          end
        end
        if (k >= 0) begin
          ret_q[o].delete(k);
          credit_i[o] = 1'b1;
        end
      end
    end
  end

  always @(negedge clk) begin : monitor
    int hit;
    int want;
    if (!reset_i) begin
      for (int i = 0; i < NP; i++) begin
        if (credit_o[i]) begin
          credit_seen[i]++;
          up_credit[i]++;
          if (up_credit[i] > DEPTH) begin
            $display("%s: input %0d got a credit for a flit never sent", cur_test, i);
            errors++;
          end
        end
      end
      for (int o = 0; o < NP; o++) begin
        if (out_valid_o[o]) begin
          hit = -1;
          want = -1;
          for (int i = 0; i < NP; i++) begin
            if (exp_q[i * NP + o].size() > 0) begin
              if (want < 0) want = i;
              if (hit < 0 && exp_q[i * NP + o][0] == out_flit_o[o]) hit = i;
            end
          end
          if (hit >= 0) begin
            void'(exp_q[hit * NP + o].pop_front());
            got_cnt[hit][o]++;
          end else if (want >= 0) begin
            $display("ERROR %s: output %0d expected %h actual %h", cur_test, o,
                     exp_q[want * NP + o][0], out_flit_o[o]);
            void'(exp_q[want * NP + o].pop_front());
            errors++;
          end else begin
            $display("%s: flit %h left on output %0d with nothing expected there",
                     cur_test, out_flit_o[o], o);
            errors++;
          end
          ret_q[o].push_back(cycle + 1 + int'(next_random() % 4));
        end
      end
    end
  end

  initial begin : run
    int err_before;
    int base [NP];
    int cnt_min;
    int cnt_max;
    int cnt;
    cur_test = "reset";
    err_before = errors;
    @(posedge clk);
    while (reset_i) begin
      @(negedge clk);
      if (out_valid_o !== '0 || credit_o !== '0) begin
        $display("reset: out_valid_o or credit_o active during reset");
        errors++;
      end
    end
    repeat (4) begin
      @(negedge clk);
      if (out_valid_o !== '0 || credit_o !== '0) begin
        $display("reset: out_valid_o or credit_o active with no input");
        errors++;
      end
    end
    @(posedge clk);
    end_test(err_before);

    cur_test = "routing";
    err_before = errors;
    for (int n = 0; n < ROUTE_FLITS; n++) begin
      queue_flit(n % NP, dest_for((n / NP) % NP));
      wait_drained(ROUTE_WAIT);
    end
    for (int o = 0; o < NP; o++) begin
      if (out_total(o) == 0) begin
        $display("routing: no flit came out on output %0d", o);
        errors++;
      end
    end
    end_test(err_before);

    cur_test = "random_order";
    err_before = errors;
    dense = 1'b0;
    for (int i = 0; i < NP; i++) begin
      for (int n = 0; n < RAND_FLITS; n++) begin
        queue_flit(i, random_dest());
      end
    end
    wait_drained(RAND_WAIT);
    for (int n = 0; n < NP * NP; n++) begin
      if (exp_q[n].size() != 0) begin
        $display("random_order: queue %0d still holds %0d flits", n, exp_q[n].size());
        errors++;
      end
    end
    end_test(err_before);

    cur_test = "backpressure";
    err_before = errors;
    dense = 1'b1;
    hold_east = 1'b1;
    base[0] = out_total(PE);
    for (int n = 0; n < BP_FLITS; n++) begin
      queue_flit(n % NP, dest_for(PE));
    end
    repeat (40) @(posedge clk);
    if (out_total(PE) - base[0] > DEPTH) begin
      $display("ERROR %s: east flits expected at most %0d actual %0d", cur_test, DEPTH,
               out_total(PE) - base[0]);
      errors++;
    end
    hold_east = 1'b0;
    wait_drained(BP_WAIT);
    if (out_total(PE) - base[0] != BP_FLITS) begin
      $display("ERROR %s: east flits expected %0d actual %0d", cur_test, BP_FLITS,
               out_total(PE) - base[0]);
      errors++;
    end
    end_test(err_before);

    cur_test = "credit_return";
    err_before = errors;
    for (int i = 0; i < NP; i++) begin
      if (credit_seen[i] != sent_cnt[i]) begin
        $display("ERROR %s: input %0d credits expected %0d actual %0d", cur_test, i,
                 sent_cnt[i], credit_seen[i]);
        errors++;
      end
    end
    end_test(err_before);

    cur_test = "fairness";
    err_before = errors;
    for (int i = 0; i < 4; i++) begin
      for (int n = 0; n < FAIR_FLITS; n++) begin
        queue_flit(i, dest_for(PL));
      end
    end
    repeat (FAIR_WARMUP) @(posedge clk);
    for (int i = 0; i < 4; i++) begin
      base[i] = got_cnt[i][PL];
    end
    repeat (FAIR_WINDOW) @(posedge clk);
    cnt_min = FAIR_WINDOW;
    cnt_max = 0;
    for (int i = 0; i < 4; i++) begin
      cnt = got_cnt[i][PL] - base[i];
      if (cnt < cnt_min) cnt_min = cnt;
      if (cnt > cnt_max) cnt_max = cnt;
      tx_q[i].delete();
    end
    if (cnt_max - cnt_min > 1) begin
      $display("ERROR %s: count spread expected at most 1 actual %0d", cur_test,
               cnt_max - cnt_min);
      errors++;
    end
    wait_drained(FAIR_WAIT);
    end_test(err_before);

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+src
src/router_pkg.sv
src/input_unit.sv
src/switch_arbiter.sv
src/crossbar_out.sv
src/mesh_router.sv
dv/tb_clock_gen.sv
dv/router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the mesh router testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f build.f --top-module router_tb -o router_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/router_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" "$log"; then
  echo "Simulation PASSED"
  exit 0
fi
echo "Simulation FAILED"
exit 1
